/* core_types_pkg.sv */
`default_nettype none

`include "pipe_consts.svh"

package core_types_pkg;

    // low two bits give the size, the top bit selects zero extension
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } mem_op_e;

    typedef enum logic [1:0] {
        res_alu = 2'd0,
        res_mul = 2'd1,
        res_div = 2'd2
    } res_src_e;

    typedef struct packed {
        logic               reg_wr;
        logic               mem_rd;
        logic               mem_wr;
        logic               error;
        logic               fence_i;
        res_src_e           res_src;
        mem_op_e            mem_op;
        logic [`REG_AW-1:0] rd;
        logic [`STRB_W-1:0] wr_mask;
        logic [`XLEN-1:0]   ex_result;  // the ALU result doubles as the memory address
        logic [`XLEN-1:0]   store_data;
        logic [`XLEN-1:0]   nxtpc;
    } ex_to_mem_t;

    typedef struct packed {
        logic               valid;
        logic               reg_wr;
        logic               error;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
        logic [`XLEN-1:0]   nxtpc;
    } wb_t;

endpackage

`default_nettype wire

/* dbus_pkg.sv */
`default_nettype none

`include "pipe_consts.svh"

package dbus_pkg;

    // encoded as log2 of the access size in bits
    typedef enum logic [2:0] {
        len_byte  = 3'd3,
        len_half  = 3'd4,
        len_word  = 3'd5,
        len_dword = 3'd6
    } wr_len_e;

    typedef struct packed {
        logic               rd;
        logic               wr;
        wr_len_e            len;
        logic [`STRB_W-1:0] mask;   // the byte lanes that a store writes
        logic [`XLEN-1:0]   addr;
        logic [`XLEN-1:0]   wdata;
    } dbus_req_t;

endpackage

`default_nettype wire

/* exec_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module exec_mem_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  core_types_pkg::ex_to_mem_t ex_in,
    input  logic [`XLEN-1:0]           op_a,
    input  logic [`XLEN-1:0]           op_b,
    input  logic [`XLEN-1:0]           dbus_rdata,
    input  logic                       dbus_ready,
    output logic                       block,
    output dbus_pkg::dbus_req_t        dbus_req,
    output core_types_pkg::wb_t        wb
);
    import core_types_pkg::*;

    logic             stage_valid;
    logic             mem_pending;
    logic             div_pending;
    logic [`XLEN-1:0] mul_result;
    logic [`XLEN-1:0] div_result;
    logic             div_done;
    wb_t              wb_ready_item;
    mem_op_e          stage_mem_op;
    logic             start_mul;
    logic             start_div;

    // the muldiv unit starts in the same edge that loads the stage
    assign start_mul = valid_in & ~block & (ex_in.res_src == res_mul);
    assign start_div = valid_in & ~block & (ex_in.res_src == res_div);

    pipe_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .stage_valid (stage_valid),
        .mem_pending (mem_pending),
        .dbus_ready  (dbus_ready),
        .div_pending (div_pending),
        .div_done    (div_done),
        .block       (block)
    );

    mem_stage u_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .ex_in         (ex_in),
        .block         (block),
        .mul_result    (mul_result),
        .div_result    (div_result),
        .div_done      (div_done),
        .dbus_ready    (dbus_ready),
        .stage_valid   (stage_valid),
        .mem_pending   (mem_pending),
        .div_pending   (div_pending),
        .dbus_req      (dbus_req),
        .wb_ready_item (wb_ready_item),
        .stage_mem_op  (stage_mem_op)
    );

    muldiv_unit u_muldiv (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_mul  (start_mul),
        .start_div  (start_div),
        .op_a       (op_a),
        .op_b       (op_b),
        .mul_result (mul_result),
        .div_result (div_result),
        .div_done   (div_done)
    );

    writeback_unit u_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .item       (wb_ready_item),
        .mem_rd     (dbus_req.rd),
        .mem_op     (stage_mem_op),
        .dbus_rdata (dbus_rdata),
        .wb         (wb)
    );

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
core_types_pkg.sv
dbus_pkg.sv
pipe_ctrl.sv
mem_stage.sv
muldiv_unit.sv
writeback_unit.sv
exec_mem_top.sv
tb_exec_mem.sv

/* mem_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module mem_stage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  core_types_pkg::ex_to_mem_t ex_in,
    input  logic                       block,
    input  logic [`XLEN-1:0]           mul_result,
    input  logic [`XLEN-1:0]           div_result,
    input  logic                       div_done,
    input  logic                       dbus_ready,
    output logic                       stage_valid,
    output logic                       mem_pending,
    output logic                       div_pending,
    output dbus_pkg::dbus_req_t        dbus_req,
    output core_types_pkg::wb_t        wb_ready_item,
    output core_types_pkg::mem_op_e    stage_mem_op
);
    import core_types_pkg::*;
    import dbus_pkg::*;

    logic             valid_q;
    ex_to_mem_t       stage_q;
    wr_len_e          len_q;
    logic             complete;
    logic [`XLEN-1:0] result;

    //////////////////////////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (!block) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            stage_q         <= ex_in;
            stage_q.fence_i <= ex_in.fence_i & valid_in & ~ex_in.error;
            case (ex_in.mem_op[1:0])
                2'b00:   len_q <= len_byte;
                2'b01:   len_q <= len_half;
                2'b10:   len_q <= len_word;
                default: len_q <= len_dword;
            endcase
        end
    end

    assign stage_valid  = valid_q;
    assign mem_pending  = stage_q.mem_rd | stage_q.mem_wr;
    assign div_pending  = stage_q.res_src == res_div;
    assign stage_mem_op = stage_q.mem_op;

    // an item is done once its bus access and its divide have both finished
    assign complete = (~mem_pending | dbus_ready) & (~div_pending | div_done);

    //////////////////////////////////////////////////////////////////////
    // bus request and result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dbus_req.rd    = valid_q & stage_q.mem_rd;
        dbus_req.wr    = valid_q & stage_q.mem_wr;
        dbus_req.len   = len_q;
        dbus_req.mask  = stage_q.wr_mask;
        dbus_req.addr  = stage_q.ex_result;
        dbus_req.wdata = stage_q.store_data;
    end

    always_comb begin
        case (stage_q.res_src)
            res_mul: result = mul_result;
            res_div: result = div_result;
            default: result = stage_q.ex_result;  // loads pass their address on for alignment
        endcase
    end

    always_comb begin
        wb_ready_item.valid  = valid_q & complete;
        wb_ready_item.reg_wr = stage_q.reg_wr;
        wb_ready_item.error  = stage_q.error;
        wb_ready_item.rd     = stage_q.rd;
        wb_ready_item.data   = result;
        wb_ready_item.nxtpc  = stage_q.nxtpc;
    end

    a_req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (dbus_req.rd || dbus_req.wr) && !dbus_ready |=> $stable(dbus_req)
    );

endmodule

`default_nettype wire

/* muldiv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module muldiv_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_mul,
    input  logic             start_div,
    input  logic [`XLEN-1:0] op_a,
    input  logic [`XLEN-1:0] op_b,
    output logic [`XLEN-1:0] mul_result,
    output logic [`XLEN-1:0] div_result,
    output logic             div_done
);

    localparam int cnt_w = $clog2(`DIV_STEPS);

    logic [`XLEN-1:0] divisor_q;
    logic [`XLEN-1:0] rem_q;
    logic [`XLEN-1:0] quo_q;
    logic [cnt_w-1:0] step_q;
    logic             busy_q;
    logic [`XLEN:0]   shifted;
    logic [`XLEN:0]   diff;

    //////////////////////////////////////////////////////////////////////
    // multiplier
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start_mul) begin
            mul_result <= op_a * op_b;  // only the low doubleword is kept
        end
    end

    //////////////////////////////////////////////////////////////////////
    // restoring divider
    //////////////////////////////////////////////////////////////////////

    assign shifted = {rem_q, quo_q[`XLEN-1]};  // the next dividend bit enters the remainder
    assign diff    = shifted - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            div_done <= 1'b0;
            step_q   <= '0;
        end else begin
            div_done <= 1'b0;
            if (start_div) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == cnt_w'(`DIV_STEPS - 1)) begin
                    busy_q   <= 1'b0;
                    div_done <= 1'b1;  // the last quotient bit lands in the same edge
                end
            end
        end
    end

    // a zero divisor never borrows, so the quotient fills with ones
    always_ff @(posedge clk) begin
        if (start_div) begin
            rem_q     <= '0;
            quo_q     <= op_a;
            divisor_q <= op_b;
        end else if (busy_q) begin
            if (!diff[`XLEN]) begin
                rem_q <= diff[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`XLEN-1:0];
                quo_q <= {quo_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    assign div_result = quo_q;

    // upstream is held while a divide runs, so no second start can arrive
    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n)
        start_div |-> !busy_q
    );

endmodule

`default_nettype wire

/* pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////////////////////////

`define XLEN      64  // data and address paths are a full doubleword wide
`define REG_AW    5   // the register file has 32 entries

//////////////////////////////////////////////////////////////////////
// muldiv and data bus
//////////////////////////////////////////////////////////////////////

`define DIV_STEPS 64  // the divider resolves one quotient bit per step
`define STRB_W    8   // there is one strobe per byte lane of the bus

`endif

/* pipe_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic stage_valid,
    input  logic mem_pending,
    input  logic dbus_ready,
    input  logic div_pending,
    input  logic div_done,
    output logic block
);

    typedef enum logic [1:0] {
        run      = 2'd0,
        mem_wait = 2'd1,
        div_wait = 2'd2
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        mem_open;
    logic        div_open;

    assign mem_open = stage_valid & mem_pending & ~dbus_ready;  // the access is still in flight
    assign div_open = stage_valid & div_pending & ~div_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= run;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        block   = 1'b0;
        case (state_q)
            run: begin
                if (mem_open) begin
                    state_d = mem_wait;
                    block   = 1'b1;   // a freshly loaded access holds upstream at once
                end else if (div_open) begin
                    state_d = div_wait;
                    block   = 1'b1;
                end
            end
            mem_wait: begin
                block = ~dbus_ready;  // the stage may advance in the ready cycle itself
                if (dbus_ready) begin
                    state_d = run;
                end
            end
            div_wait: begin
                block = ~div_done;
                if (div_done) begin
                    state_d = run;
                end
            end
            default: begin
                state_d = run;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_block_needs_stage: assert property (
        @(posedge clk) disable iff (!rst_n)
        block |-> stage_valid
    );

    // the divider only finishes while the stage still holds its divide
    a_done_expected: assert property (
        @(posedge clk) disable iff (!rst_n)
        div_done |-> stage_valid && div_pending
    );

endmodule

`default_nettype wire

/* tb_exec_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module tb_exec_mem;
    import core_types_pkg::*;
    import dbus_pkg::*;

    localparam int num_instr   = 300;
    localparam int cycle_limit = num_instr * (`DIV_STEPS + 8);
    localparam logic [1:0] k_fixed = 2'd0;  // passthrough and multiply
    localparam logic [1:0] k_div   = 2'd1;
    localparam logic [1:0] k_mem   = 2'd2;

    typedef struct packed {
        wb_t         rec;
        logic [1:0]  kind;
        logic [2:0]  len;
        logic [63:0] addr;
        logic [31:0] acc_cyc;
    } expect_t;

    logic             clk;
    logic             rst_n;
    logic             valid_in;
    ex_to_mem_t       ex_in;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] dbus_rdata;
    logic             dbus_ready;
    logic             block;
    dbus_req_t        dbus_req;
    wb_t              wb;

    integer           seed;
    int               cyc;
    int               issued;
    int               checked;
    int               errors;
    int               drain;
    int               ready_cyc;
    int               div_until;
    int               bus_wait;
    logic             bus_busy;
    logic             accepted;
    logic [`XLEN-1:0] bus_mem [256];  // what the data bus sees
    logic [`XLEN-1:0] ref_mem [256];  // updated in program order at acceptance
    expect_t          exp_q [$];

    exec_mem_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .ex_in      (ex_in),
        .op_a       (op_a),
        .op_b       (op_b),
        .dbus_rdata (dbus_rdata),
        .dbus_ready (dbus_ready),
        .block      (block),
        .dbus_req   (dbus_req),
        .wb         (wb)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic logic [63:0] fill_word(input int idx);
        logic [63:0] w;
        logic [10:0] a;
        for (int b = 0; b < 8; b++) begin
            a = 11'(idx * 8 + b);
            w[8*b +: 8] = 8'(a * 29) ^ a[10:3];  // every address bit reaches the byte
        end
        return w;
    endfunction

    function automatic logic [63:0] load_value(input logic [63:0] addr, input mem_op_e op);
        logic [63:0] lane;
        logic [63:0] keep;
        int          nbits;
        lane  = ref_mem[addr[10:3]] >> (8 * addr[2:0]);
        nbits = 8 << op[1:0];
        if (nbits == 64) begin
            return lane;
        end
        keep = (64'd1 << nbits) - 64'd1;
        lane = lane & keep;
        if (!op[2] && lane[nbits-1]) begin
            lane = lane | ~keep;  // sign extension
        end
        return lane;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic make_instr();
        int          kind;
        int          size;
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  ofs;
        r = $random(seed);
        a = $random(seed);
        kind               = $unsigned($random(seed)) % 16;
        valid_in           = ($unsigned($random(seed)) % 8) != 0;
        ex_in              = '0;
        ex_in.reg_wr       = 1'b1;
        ex_in.error        = r[0] & r[1] & r[2];
        ex_in.fence_i      = r[3];
        ex_in.rd           = r[8:4];
        ex_in.nxtpc        = {$random(seed), $random(seed)};
        ex_in.ex_result    = {$random(seed), $random(seed)};
        ex_in.store_data   = {$random(seed), $random(seed)};
        op_a               = {$random(seed), $random(seed)};
        op_b               = {$random(seed), $random(seed)};
        if (kind == 5 || kind == 6) begin
            ex_in.res_src = res_mul;
        end else if (kind == 7) begin
            ex_in.res_src = res_div;
            if (r[10:9] == 2'b00) begin
                op_b = '0;
            end else if (r[11]) begin
                op_b = op_b >> r[17:12];  // smaller divisors give wider quotients
            end
        end else if (kind >= 8) begin
            if (kind < 12) begin
                ex_in.mem_wr = 1'b1;
                ex_in.reg_wr = 1'b0;
                ex_in.mem_op = mem_op_e'({1'b0, r[19:18]});
            end else begin
                ex_in.mem_rd = 1'b1;
                ex_in.mem_op = mem_op_e'($unsigned($random(seed)) % 7);
            end
            size              = ex_in.mem_op[1:0];
            ofs               = a[8:6] & ~((8'd1 << size) - 8'd1);
            ex_in.ex_result   = {53'd0, 2'b00, a[5:0], ofs};
            ex_in.wr_mask     = 8'(((16'd1 << (1 << size)) - 16'd1) << ofs);
            ex_in.store_data  = ex_in.store_data << (8 * ofs);
        end
    endtask

    task automatic record_accept();
        expect_t e;
        e            = '0;
        e.rec.valid  = 1'b1;
        e.rec.reg_wr = ex_in.reg_wr;
        e.rec.error  = ex_in.error;
        e.rec.rd     = ex_in.rd;
        e.rec.nxtpc  = ex_in.nxtpc;
        e.acc_cyc    = cyc;
        e.kind       = k_fixed;
        e.rec.data   = ex_in.ex_result;
        if (ex_in.mem_wr || ex_in.mem_rd) begin
            e.kind = k_mem;
            e.len  = 3'd3 + ex_in.mem_op[1:0];
            e.addr = ex_in.ex_result;
            if (ex_in.mem_rd) begin
                e.rec.data = load_value(ex_in.ex_result, ex_in.mem_op);
            end else begin
                for (int b = 0; b < `STRB_W; b++) begin
                    if (ex_in.wr_mask[b]) begin
                        ref_mem[ex_in.ex_result[10:3]][8*b +: 8] = ex_in.store_data[8*b +: 8];
                    end
                end
            end
        end else if (ex_in.res_src == res_mul) begin
            e.rec.data = op_a * op_b;
        end else if (ex_in.res_src == res_div) begin
            e.kind     = k_div;
            e.rec.data = (op_b == '0) ? '1 : op_a / op_b;
            div_until  = cyc + `DIV_STEPS + 1;
        end
        exp_q.push_back(e);
        issued++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // data memory and writeback monitor
    //////////////////////////////////////////////////////////////////////

    task automatic serve_bus();
        logic [7:0] idx;
        dbus_ready = 1'b0;
        dbus_rdata = {$random(seed), $random(seed)};
        if (dbus_req.rd || dbus_req.wr) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                bus_wait = $unsigned($random(seed)) % 4;  // ready after 1 to 4 cycles
                if (exp_q.size() != 0) begin
                    check_value("bus length", dbus_req.len, exp_q[0].len);
                    check_value("bus address", dbus_req.addr, exp_q[0].addr);
                end
            end
            if (bus_wait == 0) begin
                idx        = dbus_req.addr[10:3];
                bus_busy   = 1'b0;
                dbus_ready = 1'b1;
                ready_cyc  = cyc;
                if (dbus_req.wr) begin
                    for (int b = 0; b < `STRB_W; b++) begin
                        if (dbus_req.mask[b]) begin
                            bus_mem[idx][8*b +: 8] = dbus_req.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    dbus_rdata = bus_mem[idx];
                end
            end else begin
                bus_wait = bus_wait - 1;
            end
        end
    endtask

    task automatic check_writeback();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("writeback at %0t with no accepted instruction left to match", $time);
            errors++;
            return;
        end
        e = exp_q.pop_front();
        checked++;
        check_value("wb rd", wb.rd, e.rec.rd);
        check_value("wb reg_wr", wb.reg_wr, e.rec.reg_wr);
        check_value("wb error", wb.error, e.rec.error);
        check_value("wb data", wb.data, e.rec.data);
        check_value("wb nxtpc", wb.nxtpc, e.rec.nxtpc);
        case (e.kind)
            k_fixed: check_value("latency", cyc - e.acc_cyc, 2);
            k_div:   check_value("divide latency", cyc - e.acc_cyc, `DIV_STEPS + 2);
            default: check_value("cycles after bus ready", cyc - ready_cyc, 1);
        endcase
    endtask

    initial begin
        seed       = 32'hb899;
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid_in   = 1'b0;
        ex_in      = '0;
        op_a       = '0;
        op_b       = '0;
        dbus_rdata = '0;
        dbus_ready = 1'b0;
        cyc        = 0;
        issued     = 0;
        checked    = 0;
        errors     = 0;
        drain      = 0;
        ready_cyc  = 0;
        div_until  = 0;
        bus_wait   = 0;
        bus_busy   = 1'b0;
        accepted   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            bus_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_value("block after reset", block, 0);
        check_value("bus read after reset", dbus_req.rd, 0);
        check_value("bus write after reset", dbus_req.wr, 0);
        check_value("wb valid after reset", wb.valid, 0);
        rst_n = 1'b1;

        while (cyc < cycle_limit && drain < 8) begin
            @(negedge clk);
            cyc++;
            if (wb.valid) begin
                check_writeback();
            end
            serve_bus();
            if (accepted || !valid_in) begin  // a held instruction stays on the inputs
                if (issued < num_instr) begin
                    make_instr();
                end else begin
                    valid_in = 1'b0;
                end
            end
            #1;
            accepted = valid_in && !block;
            if (cyc < div_until) begin
                check_value("block during divide", block, 1);
            end
            if (accepted) begin
                record_accept();
            end
            if (issued == num_instr && exp_q.size() == 0) begin
                drain++;
            end
        end

        // stores reach the bus memory through the strobes and write data of the request
        for (int i = 0; i < 256; i++) begin
            check_value("memory word", bus_mem[i], ref_mem[i]);
        end

        if (cyc >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d writebacks still missing",
                     cyc, exp_q.size());
            errors++;
        end
        $display("%0d of %0d writebacks checked, %0d errors", checked, issued, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* writeback_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pipe_consts.svh"

module writeback_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_types_pkg::wb_t     item,
    input  logic                    mem_rd,
    input  core_types_pkg::mem_op_e mem_op,
    input  logic [`XLEN-1:0]        dbus_rdata,
    output core_types_pkg::wb_t     wb
);
    import core_types_pkg::*;

    localparam int ofs_w = $clog2(`STRB_W);

    logic [`XLEN-1:0] lane;
    logic [`XLEN-1:0] load_data;

    // the bus returns the whole doubleword, so the addressed byte moves to lane 0
    assign lane = dbus_rdata >> {item.data[ofs_w-1:0], 3'b000};

    always_comb begin
        case (mem_op)
            lb:      load_data = {{(`XLEN-8){lane[7]}}, lane[7:0]};
            lbu:     load_data = {{(`XLEN-8){1'b0}}, lane[7:0]};
            lh:      load_data = {{(`XLEN-16){lane[15]}}, lane[15:0]};
            lhu:     load_data = {{(`XLEN-16){1'b0}}, lane[15:0]};
            lw:      load_data = {{(`XLEN-32){lane[31]}}, lane[31:0]};
            lwu:     load_data = {{(`XLEN-32){1'b0}}, lane[31:0]};
            default: load_data = lane;  // a doubleword load needs no extension
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= item.valid;
        end
        if (item.valid) begin
            wb.reg_wr <= item.reg_wr;
            wb.error  <= item.error;
            wb.rd     <= item.rd;
            wb.data   <= mem_rd ? load_data : item.data;
            wb.nxtpc  <= item.nxtpc;
        end
    end

endmodule

`default_nettype wire
